/* Makefile */
# Verilator build, run and lint for the OHCI list service subsystem

SIM = obj_dir/Vohci_list_tb

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

$(SIM): ohci_list_top.f rtl/*.sv test/ohci_list_tb.sv
	verilator --binary --timing --top-module ohci_list_tb -f ohci_list_top.f

lint:
	verilator --lint-only -Wall --top-module ohci_list_top rtl/ohci_pkg.sv \
	  rtl/ohci_ed_unpack.sv rtl/ohci_ed_fetch.sv rtl/ohci_list_regs.sv \
	  rtl/ohci_list_service.sv rtl/ohci_list_top.sv

clean:
	rm -rf obj_dir sim.log

/* ohci_list_top.f */
rtl/ohci_pkg.sv
rtl/ohci_ed_unpack.sv
rtl/ohci_ed_fetch.sv
rtl/ohci_list_regs.sv
rtl/ohci_list_service.sv
rtl/ohci_list_top.sv
test/ohci_list_tb.sv

/* rtl/ohci_ed_fetch.sv */
// OHCI ED fetch unit
// Issues one read pulse per ED and gathers the four returned words,
// flagging the ED complete in the cycle of the last data beat
`timescale 1ns/100ps
`default_nettype none

module ohci_ed_fetch (
  input  logic                                 soc_clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 start_i,
  input  logic [ohci_pkg::PTR_W-1:0]           addr_i,
  output logic                                 mem_rd_o,
  output logic [31:0]                          mem_addr_o,
  input  logic                                 mem_rvalid_i,
  input  logic [31:0]                          mem_rdata_i,
  output logic [ohci_pkg::ED_WORDS-1:0][31:0]  words_o,
  output logic                                 words_valid_o
);

  import ohci_pkg::*;

  logic                        rd_q;
  logic [ED_CNT_W-1:0]         cnt_q;     // Index of the next expected word
  logic [PTR_W-1:0]            addr_q;
  // Last word is taken straight from the bus
  logic [ED_WORDS-2:0][31:0]   word_q;
  logic                        last_beat;

  assign last_beat = mem_rvalid_i && (cnt_q == ED_CNT_W'(ED_WORDS - 1));

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_q  <= 1'b0;
      cnt_q <= '0;
    end else begin
      rd_q <= start_i;
      if (start_i) cnt_q <= '0;
      else if (mem_rvalid_i) cnt_q <= cnt_q + ED_CNT_W'(1);
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (start_i) addr_q <= addr_i;
    if (mem_rvalid_i && !last_beat) begin
      word_q[cnt_q] <= mem_rdata_i;
    end
  end

  // One-cycle read strobe with the aligned ED address
  assign mem_rd_o      = rd_q;
  assign mem_addr_o    = {addr_q, 4'b0000};
  assign words_o       = {mem_rdata_i, word_q};
  assign words_valid_o = last_beat;

endmodule

`default_nettype wire

/* rtl/ohci_ed_unpack.sv */
// OHCI ED decoder
// Splits the four raw ED words into the endpoint descriptor fields
// following the OHCI ED layout, purely combinational
`timescale 1ns/100ps
`default_nettype none

module ohci_ed_unpack (
  input  logic [ohci_pkg::ED_WORDS-1:0][31:0] words_i,
  output ohci_pkg::ohci_ed_t                  ed_o
);

  // Word 0, endpoint control
  assign ed_o.fa     = words_i[0][6:0];
  assign ed_o.ep     = words_i[0][10:7];
  assign ed_o.dir    = words_i[0][12:11];
  assign ed_o.speed  = words_i[0][13];
  assign ed_o.skip   = words_i[0][14];
  assign ed_o.format = words_i[0][15];
  assign ed_o.mps    = words_i[0][26:16];

  // Word 1, TD queue tail
  assign ed_o.tail_p = words_i[1][31:4];

  // Word 2, TD queue head with halted and toggle carry in the low bits
  assign ed_o.head_p       = words_i[2][31:4];
  assign ed_o.toggle_carry = words_i[2][1];
  assign ed_o.halted       = words_i[2][0];

  // Word 3, link to the next ED
  assign ed_o.next_ed = words_i[3][31:4];

endmodule

`default_nettype wire

/* rtl/ohci_list_regs.sv */
// OHCI operational registers
// Control word plus head and current ED pointers for the three lists
// Software access through a simple write strobe and combinational read
// Hardware current-pointer updates win over software writes
`timescale 1ns/100ps
`default_nettype none

module ohci_list_regs (
  input  logic                         soc_clk_i,
  input  logic                         rst_n_i,
  input  logic                         reg_we_i,
  input  logic [ohci_pkg::ADDR_W-1:0]  reg_addr_i,
  input  logic [31:0]                  reg_wdata_i,
  output logic [31:0]                  reg_rdata_o,
  input  ohci_pkg::ohci_ptr_upd_t      upd_i,
  input  logic                         np2p_i,
  output ohci_pkg::ohci_ctrl_t         ctrl_o,
  output logic [ohci_pkg::PTR_W-1:0]   period_head_o,
  output logic [ohci_pkg::PTR_W-1:0]   period_cur_o,
  output logic [ohci_pkg::PTR_W-1:0]   ctrl_head_o,
  output logic [ohci_pkg::PTR_W-1:0]   ctrl_cur_o,
  output logic [ohci_pkg::PTR_W-1:0]   bulk_head_o,
  output logic [ohci_pkg::PTR_W-1:0]   bulk_cur_o
);

  import ohci_pkg::*;

  ohci_ctrl_t       ctrl_q;
  // Only pointer bits 31:4 are stored, low nibble reads as zero
  logic [PTR_W-1:0] period_head_q;
  logic [PTR_W-1:0] period_cur_q;
  logic [PTR_W-1:0] ctrl_head_q;
  logic [PTR_W-1:0] ctrl_cur_q;
  logic [PTR_W-1:0] bulk_head_q;
  logic [PTR_W-1:0] bulk_cur_q;

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q        <= '0;
      period_head_q <= '0;
      period_cur_q  <= '0;
      ctrl_head_q   <= '0;
      ctrl_cur_q    <= '0;
      bulk_head_q   <= '0;
      bulk_cur_q    <= '0;
    end else begin
      // Software write first, later assignments take priority
      if (reg_we_i) begin
        case (reg_addr_i)
          REG_CONTROL:     ctrl_q <= ohci_ctrl_t'(reg_wdata_i[$bits(ohci_ctrl_t)-1:0]);
          REG_PERIOD_HEAD: period_head_q <= reg_wdata_i[31:4];
          REG_CTRL_HEAD:   ctrl_head_q   <= reg_wdata_i[31:4];
          REG_CTRL_CUR:    ctrl_cur_q    <= reg_wdata_i[31:4];
          REG_BULK_HEAD:   bulk_head_q   <= reg_wdata_i[31:4];
          REG_BULK_CUR:    bulk_cur_q    <= reg_wdata_i[31:4];
          REG_PERIOD_CUR:  period_cur_q  <= reg_wdata_i[31:4];
          default: ;
        endcase
      end
      // Next pointer of a finished visit
      if (upd_i.valid) begin
        case (upd_i.channel)
          CH_PERIODIC: period_cur_q <= upd_i.addr;
          CH_CONTROL:  ctrl_cur_q   <= upd_i.addr;
          CH_BULK:     bulk_cur_q   <= upd_i.addr;
          default: ;
        endcase
      end
      // New frame restarts the periodic walk at its head
      if (np2p_i) begin
        period_cur_q <= period_head_q;
      end
    end
  end

  // Read-back mux
  always_comb begin
    case (reg_addr_i)
      REG_CONTROL:     reg_rdata_o = 32'(ctrl_q);
      REG_PERIOD_HEAD: reg_rdata_o = {period_head_q, 4'b0000};
      REG_CTRL_HEAD:   reg_rdata_o = {ctrl_head_q, 4'b0000};
      REG_CTRL_CUR:    reg_rdata_o = {ctrl_cur_q, 4'b0000};
      REG_BULK_HEAD:   reg_rdata_o = {bulk_head_q, 4'b0000};
      REG_BULK_CUR:    reg_rdata_o = {bulk_cur_q, 4'b0000};
      REG_PERIOD_CUR:  reg_rdata_o = {period_cur_q, 4'b0000};
      default:         reg_rdata_o = '0;
    endcase
  end

  assign ctrl_o        = ctrl_q;
  assign period_head_o = period_head_q;
  assign period_cur_o  = period_cur_q;
  assign ctrl_head_o   = ctrl_head_q;
  assign ctrl_cur_o    = ctrl_cur_q;
  assign bulk_head_o   = bulk_head_q;
  assign bulk_cur_o    = bulk_cur_q;

endmodule

`default_nettype wire

/* rtl/ohci_list_service.sv */
// OHCI list service controller
// Picks periodic, control or bulk ED to visit, applies the control/bulk
// service ratio, starts the ED fetch and reports each finished visit
// with a current-pointer update
`timescale 1ns/100ps
`default_nettype none

module ohci_list_service (
  input  logic                        soc_clk_i,
  input  logic                        rst_n_i,
  input  logic                        frame_periodic_i,
  input  ohci_pkg::ohci_ctrl_t        ctrl_i,
  input  logic [ohci_pkg::PTR_W-1:0]  period_head_i,
  input  logic [ohci_pkg::PTR_W-1:0]  period_cur_i,
  input  logic [ohci_pkg::PTR_W-1:0]  ctrl_head_i,
  input  logic [ohci_pkg::PTR_W-1:0]  ctrl_cur_i,
  input  logic [ohci_pkg::PTR_W-1:0]  bulk_head_i,
  input  logic [ohci_pkg::PTR_W-1:0]  bulk_cur_i,
  input  ohci_pkg::ohci_ed_t          ed_i,
  input  logic                        ed_valid_i,
  output logic                        fetch_start_o,
  output logic [ohci_pkg::PTR_W-1:0]  fetch_addr_o,
  output ohci_pkg::ohci_ptr_upd_t     upd_o,
  output logic                        np2p_o,
  output logic                        ed_done_o,
  output ohci_pkg::ohci_ed_info_t     ed_info_o
);

  import ohci_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_CHOOSE, S_FETCH, S_DONE} state_e;

  state_e           state_q, state_d;
  logic             frame_q;
  logic [2:0]       ratio_cnt_q;   // Control EDs served since last bulk
  // Visit in flight
  ohci_channel_e    vis_ch_q;
  logic [PTR_W-1:0] vis_addr_q;
  logic [PTR_W-1:0] next_q;
  ohci_ed_info_t    info_q;
  // List choice
  logic [PTR_W-1:0] period_addr;
  logic [PTR_W-1:0] ctrl_addr, bulk_addr;
  logic             ctrl_avail, bulk_avail, want_ctrl;
  logic             pick_valid;
  ohci_channel_e    pick_ch;
  logic [PTR_W-1:0] pick_addr;

  // Head reload on the rising edge of the periodic part when ple is set
  assign np2p_o = frame_periodic_i && !frame_q && ctrl_i.ple;

  // Rising edge cycle starts from the head while period_cur loads it
  assign period_addr = frame_q ? period_cur_i : period_head_i;

  // Empty current pointer falls back to the head
  assign ctrl_addr  = (ctrl_cur_i != '0) ? ctrl_cur_i : ctrl_head_i;
  assign bulk_addr  = (bulk_cur_i != '0) ? bulk_cur_i : bulk_head_i;
  assign ctrl_avail = ctrl_i.cle && (ctrl_addr != '0);
  assign bulk_avail = ctrl_i.ble && (bulk_addr != '0);
  assign want_ctrl  = ratio_cnt_q <= {1'b0, ctrl_i.cbsr};

  always_comb begin
    pick_valid = 1'b0;
    pick_ch    = CH_CONTROL;
    pick_addr  = '0;
    if (frame_periodic_i) begin
      // Periodic part runs until the list ends
      if (ctrl_i.ple && (period_addr != '0)) begin
        pick_valid = 1'b1;
        pick_ch    = CH_PERIODIC;
        pick_addr  = period_addr;
      end
    end else if (ctrl_avail && (want_ctrl || !bulk_avail)) begin
      pick_valid = 1'b1;
      pick_ch    = CH_CONTROL;
      pick_addr  = ctrl_addr;
    end else if (bulk_avail) begin
      pick_valid = 1'b1;
      pick_ch    = CH_BULK;
      pick_addr  = bulk_addr;
    end
  end

  assign fetch_start_o = (state_q == S_CHOOSE) && ctrl_i.oper && pick_valid;
  assign fetch_addr_o  = pick_addr;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (ctrl_i.oper) state_d = S_CHOOSE;
      S_CHOOSE: begin
        if (fetch_start_o) state_d = S_FETCH;
        else if (!ctrl_i.oper) state_d = S_IDLE;
      end
      S_FETCH:  if (ed_valid_i) state_d = S_DONE;
      S_DONE:   state_d = S_CHOOSE;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      frame_q     <= 1'b0;
      ratio_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      frame_q <= frame_periodic_i;
      // Ratio bookkeeping once a visit completes
      if (state_q == S_DONE) begin
        if (vis_ch_q == CH_BULK) ratio_cnt_q <= '0;
        else if (vis_ch_q == CH_CONTROL && want_ctrl) ratio_cnt_q <= ratio_cnt_q + 3'd1;
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (fetch_start_o) begin
      vis_ch_q   <= pick_ch;
      vis_addr_q <= pick_addr;
    end
    // Capture the decoded ED while the fourth word is on the bus
    if (ed_valid_i) begin
      next_q            <= ed_i.next_ed;
      info_q.ed_addr    <= vis_addr_q;
      info_q.channel    <= vis_ch_q;
      info_q.fa         <= ed_i.fa;
      info_q.ep         <= ed_i.ep;
      info_q.td_pending <= !ed_i.skip && !ed_i.halted && (ed_i.head_p != ed_i.tail_p);
    end
  end

  // Report and pointer update in the same cycle
  assign ed_done_o     = (state_q == S_DONE);
  assign ed_info_o     = info_q;
  assign upd_o.valid   = (state_q == S_DONE);
  assign upd_o.channel = vis_ch_q;
  assign upd_o.addr    = next_q;

endmodule

`default_nettype wire

/* rtl/ohci_list_top.sv */
// OHCI list service subsystem top
// Register file, list service controller, ED fetch and ED decode
`timescale 1ns/100ps
`default_nettype none

module ohci_list_top (
  input  logic                         soc_clk_i,
  input  logic                         rst_n_i,
  // Register port
  input  logic                         reg_we_i,
  input  logic [ohci_pkg::ADDR_W-1:0]  reg_addr_i,
  input  logic [31:0]                  reg_wdata_i,
  output logic [31:0]                  reg_rdata_o,
  // Frame phase from the frame counter
  input  logic                         frame_periodic_i,
  // System memory read port
  output logic                         mem_rd_o,
  output logic [31:0]                  mem_addr_o,
  input  logic                         mem_rvalid_i,
  input  logic [31:0]                  mem_rdata_i,
  // Visit report
  output logic                         ed_done_o,
  output ohci_pkg::ohci_ed_info_t      ed_info_o
);

  import ohci_pkg::*;

  ohci_ctrl_t                hc_ctrl;
  logic [PTR_W-1:0]          period_head, period_cur;
  logic [PTR_W-1:0]          ctrl_head, ctrl_cur;
  logic [PTR_W-1:0]          bulk_head, bulk_cur;
  ohci_ptr_upd_t             upd;
  logic                      np2p;
  logic                      fetch_start;
  logic [PTR_W-1:0]          fetch_addr;
  logic [ED_WORDS-1:0][31:0] words;
  logic                      words_valid;
  ohci_ed_t                  ed;

  ohci_list_regs i_list_regs (
    .soc_clk_i     ( soc_clk_i   ),
    .rst_n_i       ( rst_n_i     ),
    .reg_we_i      ( reg_we_i    ),
    .reg_addr_i    ( reg_addr_i  ),
    .reg_wdata_i   ( reg_wdata_i ),
    .reg_rdata_o   ( reg_rdata_o ),
    .upd_i         ( upd         ),
    .np2p_i        ( np2p        ),
    .ctrl_o        ( hc_ctrl     ),
    .period_head_o ( period_head ),
    .period_cur_o  ( period_cur  ),
    .ctrl_head_o   ( ctrl_head   ),
    .ctrl_cur_o    ( ctrl_cur    ),
    .bulk_head_o   ( bulk_head   ),
    .bulk_cur_o    ( bulk_cur    )
  );

  ohci_list_service i_list_service (
    .soc_clk_i        ( soc_clk_i        ),
    .rst_n_i          ( rst_n_i          ),
    .frame_periodic_i ( frame_periodic_i ),
    .ctrl_i           ( hc_ctrl          ),
    .period_head_i    ( period_head      ),
    .period_cur_i     ( period_cur       ),
    .ctrl_head_i      ( ctrl_head        ),
    .ctrl_cur_i       ( ctrl_cur         ),
    .bulk_head_i      ( bulk_head        ),
    .bulk_cur_i       ( bulk_cur         ),
    .ed_i             ( ed               ),
    .ed_valid_i       ( words_valid      ),
    .fetch_start_o    ( fetch_start      ),
    .fetch_addr_o     ( fetch_addr       ),
    .upd_o            ( upd              ),
    .np2p_o           ( np2p             ),
    .ed_done_o        ( ed_done_o        ),
    .ed_info_o        ( ed_info_o        )
  );

  ohci_ed_fetch i_ed_fetch (
    .soc_clk_i     ( soc_clk_i    ),
    .rst_n_i       ( rst_n_i      ),
    .start_i       ( fetch_start  ),
    .addr_i        ( fetch_addr   ),
    .mem_rd_o      ( mem_rd_o     ),
    .mem_addr_o    ( mem_addr_o   ),
    .mem_rvalid_i  ( mem_rvalid_i ),
    .mem_rdata_i   ( mem_rdata_i  ),
    .words_o       ( words        ),
    .words_valid_o ( words_valid  )
  );

  // Decode is combinational, fields valid with words_valid
  ohci_ed_unpack i_ed_unpack (
    .words_i ( words ),
    .ed_o    ( ed    )
  );

endmodule

`default_nettype wire

/* rtl/ohci_pkg.sv */
// OHCI list service shared definitions
// Channel type, control register fields, ED layout and per-visit report,
// plus the operational register indices
`default_nettype none

package ohci_pkg;

  // ED geometry and pointer width (pointers are 16-byte aligned)
  localparam int unsigned ED_WORDS = 4;
  localparam int unsigned ED_CNT_W = $clog2(ED_WORDS);
  localparam int unsigned PTR_W    = 28;

  // Register index width and word indices
  localparam int unsigned ADDR_W = 4;
  localparam logic [ADDR_W-1:0] REG_CONTROL     = 4'd0;
  localparam logic [ADDR_W-1:0] REG_PERIOD_HEAD = 4'd1;
  localparam logic [ADDR_W-1:0] REG_CTRL_HEAD   = 4'd2;
  localparam logic [ADDR_W-1:0] REG_CTRL_CUR    = 4'd3;
  localparam logic [ADDR_W-1:0] REG_BULK_HEAD   = 4'd4;
  localparam logic [ADDR_W-1:0] REG_BULK_CUR    = 4'd5;
  localparam logic [ADDR_W-1:0] REG_PERIOD_CUR  = 4'd6;

  // Which list an ED belongs to
  typedef enum logic [1:0] {
    CH_PERIODIC = 2'd0,
    CH_CONTROL  = 2'd1,
    CH_BULK     = 2'd2
  } ohci_channel_e;

  // Control word, cbsr in the low bits like HcControl
  typedef struct packed {
    logic [2:0] spare;
    logic       oper;   // Operational state
    logic       ble;
    logic       cle;
    logic       ple;
    logic [1:0] cbsr;   // Control/bulk service ratio minus one
  } ohci_ctrl_t;

  // One decoded endpoint descriptor
  typedef struct packed {
    logic [PTR_W-1:0] next_ed;
    logic             halted;
    logic             toggle_carry;
    logic [PTR_W-1:0] head_p;
    logic [PTR_W-1:0] tail_p;
    logic [10:0]      mps;
    logic             format;
    logic             skip;
    logic             speed;
    logic [1:0]       dir;
    logic [3:0]       ep;
    logic [6:0]       fa;
  } ohci_ed_t;

  // Report of one visited ED
  typedef struct packed {
    logic [PTR_W-1:0] ed_addr;
    ohci_channel_e    channel;
    logic [6:0]       fa;
    logic [3:0]       ep;
    logic             td_pending;
  } ohci_ed_info_t;

  // Hardware write of a current-ED register
  typedef struct packed {
    logic             valid;
    ohci_channel_e    channel;
    logic [PTR_W-1:0] addr;
  } ohci_ptr_upd_t;

endpackage

`default_nettype wire

/* test/ohci_list_tb.sv */
// Testbench for the OHCI list service subsystem
// Replays the script in test/ohci_testdata.txt: register writes and reads,
// frame phase changes, idle windows and expected ED visits
// Memory model answers each ED read with four beats after random gaps
`timescale 1ns/100ps
`default_nettype none

module ohci_list_tb;

  import ohci_pkg::*;

  localparam int VISIT_CYCLES = 300;

  // Script record, command letter and up to six hex fields
  typedef struct packed {
    logic [7:0]       cmd;
    logic [5:0][31:0] arg;
  } record_t;

  logic              soc_clk_i;
  logic              rst_n_i;
  logic              reg_we_i;
  logic [ADDR_W-1:0] reg_addr_i;
  logic [31:0]       reg_wdata_i;
  logic [31:0]       reg_rdata_o;
  logic              frame_periodic_i;
  logic              mem_rd_o;
  logic [31:0]       mem_addr_o;
  logic              mem_rvalid_i;
  logic [31:0]       mem_rdata_i;
  logic              ed_done_o;
  ohci_ed_info_t     ed_info_o;

  // Memory image by byte address, command script
  logic [31:0] mem [logic [31:0]];
  record_t     script [$];
  int          n_visits = 0;
  int          quiet_cycles = 0;
  int          limit_cycles = 0;
  // Visits consumed by the script vs. events seen on the bus
  int          visit_cnt = 0;
  int          done_cnt = 0;
  int          rd_cnt = 0;

  ohci_list_top i_ohci_list_top (
    .soc_clk_i        ( soc_clk_i        ),
    .rst_n_i          ( rst_n_i          ),
    .reg_we_i         ( reg_we_i         ),
    .reg_addr_i       ( reg_addr_i       ),
    .reg_wdata_i      ( reg_wdata_i      ),
    .reg_rdata_o      ( reg_rdata_o      ),
    .frame_periodic_i ( frame_periodic_i ),
    .mem_rd_o         ( mem_rd_o         ),
    .mem_addr_o       ( mem_addr_o       ),
    .mem_rvalid_i     ( mem_rvalid_i     ),
    .mem_rdata_i      ( mem_rdata_i      ),
    .ed_done_o        ( ed_done_o        ),
    .ed_info_o        ( ed_info_o        )
  );

  always #10 soc_clk_i = ~soc_clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Parse the data file, memory words go straight into the image
  task automatic load_script();
    int          fd;
    int          n;
    int          nargs;
    int          i;
    string       tok;
    string       line;
    logic [7:0]  c;
    logic [31:0] v [6];
    record_t     rec;
    fd = $fopen("test/ohci_testdata.txt", "r");
    if (fd == 0) abort_run("Cannot open test/ohci_testdata.txt");
    while ($fscanf(fd, "%s", tok) == 1) begin
      c = tok[0];
      nargs = 0;
      case (c)
        "#": n = $fgets(line, fd);
        "M": nargs = 5;
        "E": nargs = 6;
        "W", "R": nargs = 2;
        "F", "Q": nargs = 1;
        default: abort_run({"Unknown record in data file: ", tok});
      endcase
      if (c != "#") begin
        rec = '0;
        rec.cmd = c;
        for (i = 0; i < nargs; i++) begin
          n = $fscanf(fd, "%h", v[i]);
          if (n != 1) abort_run("Short record in data file");
          rec.arg[i] = v[i];
        end
        if (c == "M") begin
          for (i = 0; i < 4; i++) mem[v[0] + 32'(4 * i)] = v[i + 1];
        end else begin
          if (c == "E") n_visits++;
          if (c == "Q") quiet_cycles += int'(v[0]);
          script.push_back(rec);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic write_reg(input logic [31:0] idx, input logic [31:0] data);
    @(negedge soc_clk_i);
    reg_we_i    = 1'b1;
    reg_addr_i  = idx[ADDR_W-1:0];
    reg_wdata_i = data;
    @(negedge soc_clk_i);
    reg_we_i = 1'b0;
  endtask

  // Read path is combinational, sample just after the address settles
  task automatic read_reg(input logic [31:0] idx, input logic [31:0] exp);
    @(negedge soc_clk_i);
    reg_addr_i = idx[ADDR_W-1:0];
    #1;
    check_value("reg_rdata_o", reg_rdata_o, exp);
  endtask

  // Fields: ED address, channel, fa, ep, pending, next ED
  task automatic expect_visit(input logic [5:0][31:0] a);
    logic [31:0] cur_idx;
    while (!ed_done_o) @(negedge soc_clk_i);
    check_value("ed_info_o.ed_addr", {ed_info_o.ed_addr, 4'b0000}, a[0]);
    check_value("ed_info_o.channel", 32'(ed_info_o.channel), a[1]);
    check_value("ed_info_o.fa", 32'(ed_info_o.fa), a[2]);
    check_value("ed_info_o.ep", 32'(ed_info_o.ep), a[3]);
    check_value("ed_info_o.td_pending", 32'(ed_info_o.td_pending), a[4]);
    visit_cnt++;
    // Served list's current register, written at the end of the done cycle
    case (a[1])
      32'd0:   cur_idx = 32'(REG_PERIOD_CUR);
      32'd1:   cur_idx = 32'(REG_CTRL_CUR);
      default: cur_idx = 32'(REG_BULK_CUR);
    endcase
    read_reg(cur_idx, a[5]);
  endtask

  // Nothing may start or finish inside the window
  task automatic idle_window(input logic [31:0] n);
    repeat (n) @(negedge soc_clk_i);
    #1;
    if (done_cnt != visit_cnt) abort_run("Extra ed_done_o without an expected visit");
    if (rd_cnt != visit_cnt) abort_run("Memory read started while no visit was expected");
  endtask

  task automatic serve_read(input logic [31:0] addr);
    int          gap;
    int          w;
    logic [31:0] a;
    for (w = 0; w < 4; w++) begin
      gap = int'($urandom_range(3, 0));
      a = addr + 32'(4 * w);
      repeat (gap) @(negedge soc_clk_i);
      if (!mem.exists(a)) abort_run($sformatf("Memory read at 0x%08h outside the image", a));
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = mem[a];
      @(negedge soc_clk_i);
      mem_rvalid_i = 1'b0;
    end
  endtask

  // Memory model
  always begin
    @(negedge soc_clk_i);
    if (rst_n_i && mem_rd_o) serve_read(mem_addr_o);
  end

  // Bus event counters
  always @(negedge soc_clk_i) begin
    if (ed_done_o) done_cnt++;
    if (mem_rd_o) rd_cnt++;
  end

  // Watchdog, armed once the script length is known
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge soc_clk_i);
    abort_run("Timeout, the expected visits did not complete in time");
  end

  initial begin
    record_t rec;
    void'($urandom(11));
    soc_clk_i        = 1'b0;
    rst_n_i          = 1'b0;
    reg_we_i         = 1'b0;
    reg_addr_i       = '0;
    reg_wdata_i      = '0;
    frame_periodic_i = 1'b0;
    mem_rvalid_i     = 1'b0;
    mem_rdata_i      = '0;
    load_script();
    limit_cycles = 4 + VISIT_CYCLES * n_visits + quiet_cycles + 4 * script.size();
    repeat (4) @(negedge soc_clk_i);
    rst_n_i = 1'b1;
    foreach (script[i]) begin
      rec = script[i];
      case (rec.cmd)
        "W": write_reg(rec.arg[0], rec.arg[1]);
        "R": read_reg(rec.arg[0], rec.arg[1]);
        "E": expect_visit(rec.arg);
        "Q": idle_window(rec.arg[0]);
        "F": begin
          @(negedge soc_clk_i);
          frame_periodic_i = rec.arg[0][0];
        end
        default: ;
      endcase
    end
    if (done_cnt == visit_cnt) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("Extra ed_done_o after the last expected visit");
    end
  end

endmodule

`default_nettype wire

/* test/ohci_testdata.txt */
# All values hex. W reg data | R reg expect | F frame_periodic | Q idle cycles
# M ed_addr word0 word1 word2 word3 | E ed_addr channel fa ep td_pending next_ed
M 1000 00400005 00004000 00004010 00001010
M 1010 00400086 00004100 00004100 00000000
M 2000 00405107 00005000 00005010 00002010
M 2010 00400988 00005100 00005111 00000000
M 3000 00080209 00006000 00006012 00003010
M 3010 0008028a 00006100 00006200 00000000
# Reset values, then heads with the low nibble dropped
R 0 0
R 1 0
R 3 0
R 5 0
R 6 0
W 1 3000
W 2 1000
W 4 2009
R 1 3000
R 4 2000
# Not operational, no reads
Q 20
W 0 3d
R 0 3d
# Two control EDs per bulk ED
E 1000 1 5 0 1 1010
E 1010 1 6 1 0 0
E 2000 2 7 2 0 2010
E 1000 1 5 0 1 1010
E 1010 1 6 1 0 0
E 2010 2 8 3 0 0
# Periodic part of the frame
F 1
E 1000 1 5 0 1 1010
E 3000 0 9 4 1 3010
E 3010 0 a 5 1 0
F 0
E 1010 1 6 1 0 0
E 2000 2 7 2 0 2010
# Bulk disabled, then control head cleared
W 0 2d
E 1000 1 5 0 1 1010
E 1010 1 6 1 0 0
W 2 0
R 2 0
E 1000 1 5 0 1 1010
E 1010 1 6 1 0 0
Q 40
